/* frontend.f */
logic/axi_pkg.sv
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/icache_bypass.sv
logic/instr_buffer.sv
logic/axi_read_bridge.sv
logic/frontend_top.sv
verification/frontend_tb.sv

/* logic/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  // id field width on AR and R
  localparam int ID_W = 4;

  // instruction fetch uses one fixed id
  localparam logic [ID_W-1:0] AR_ID_FETCH = 4'd0;

  // arsize code, 2**2 bytes per beat
  localparam logic [2:0] SIZE_WORD = 3'd2;

  // arburst codes
  localparam logic [1:0] BURST_INCR = 2'd1;

  // rresp codes
  localparam logic [1:0] RESP_OKAY = 2'd0;

endpackage

`default_nettype wire

/* logic/axi_read_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_bridge (
  input  logic                          aclk,
  input  logic                          reset,
  // word read port
  input  logic                          rd_req,
  input  logic [2:0]                    rd_type,
  input  logic [fetch_pkg::ADDR_W-1:0]  rd_addr,
  output logic                          rd_rdy,
  output logic                          ret_valid,
  output logic                          ret_last,
  output logic [fetch_pkg::INSTR_W-1:0] ret_data,
  // AR channel
  output logic [axi_pkg::ID_W-1:0]      arid,
  output logic [31:0]                   araddr,
  output logic [7:0]                    arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic [1:0]                    arlock,
  output logic [3:0]                    arcache,
  output logic [2:0]                    arprot,
  output logic                          arvalid,
  input  logic                          arready,
  // R channel
  input  logic [axi_pkg::ID_W-1:0]      rid,
  input  logic [31:0]                   rdata,
  input  logic [1:0]                    rresp,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready
);

  localparam logic [1:0] s_idle = 2'd0;
  localparam logic [1:0] s_addr = 2'd1;
  localparam logic [1:0] s_data = 2'd2;

  logic [1:0] state;

  assign rd_rdy  = state == s_idle;
  assign arvalid = state == s_addr;
  assign rready  = state == s_data;

  // single beat INCR word read, normal access
  assign arid    = axi_pkg::AR_ID_FETCH;
  assign arlen   = 8'd0;
  assign arsize  = axi_pkg::SIZE_WORD;
  assign arburst = axi_pkg::BURST_INCR;
  assign arlock  = 2'b00;
  assign arcache = 4'b0000;
  assign arprot  = 3'b000;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state     <= s_idle;
      ret_valid <= 1'b0;
    end else begin
      case (state)
        s_idle:  if (rd_req) state <= s_addr;
        s_addr:  if (arready) state <= s_data;
        s_data:  if (rvalid) state <= s_idle;
        default: state <= s_idle;
      endcase
      ret_valid <= rvalid && rready;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_req && rd_rdy) araddr <= rd_addr;
    if (rvalid && rready) begin
      ret_data <= rdata;
      ret_last <= rlast;
    end
  end

  a_ar_stable: assert property (
    @(posedge aclk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr)
  );

  // slave answers with the fetch id, OKAY and a single last beat
  a_r_beat: assert property (
    @(posedge aclk) disable iff (reset)
    rvalid && rready |-> rid == axi_pkg::AR_ID_FETCH && rresp == axi_pkg::RESP_OKAY && rlast
  );

  a_rd_word: assert property (
    @(posedge aclk) disable iff (reset)
    rd_req && rd_rdy |-> rd_type == fetch_pkg::RD_TYPE_WORD
  );

endmodule

`default_nettype wire

/* logic/fetch_pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen #(
  parameter int                           ib_depth = 8,
  parameter logic [fetch_pkg::ADDR_W-1:0] reset_pc = fetch_pkg::RESET_PC,
  localparam int                          cnt_w    = $clog2(ib_depth) + 1
) (
  input  logic                         aclk,
  input  logic                         reset,
  // redirect from the back end
  input  logic                         jump_valid,
  input  logic [fetch_pkg::ADDR_W-1:0] jump_pc,
  // buffer space and fetch completion
  input  logic [cnt_w-1:0]             free_count,
  input  logic                         fetch_done,
  // request toward the icache
  output logic                         fetch_valid,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_pc,
  input  logic                         addr_ok
);

  logic in_flight;
  logic accept;
  logic room;

  assign accept = fetch_valid && addr_ok;

  // one word in flight plus the next one
  assign room = free_count >= cnt_w'(2);

  always_ff @(posedge aclk) begin
    if (reset) begin
      fetch_pc    <= reset_pc;
      in_flight   <= 1'b0;
      fetch_valid <= 1'b0;
    end else begin
      // redirect takes priority over the sequential step
      if (jump_valid) begin
        fetch_pc <= jump_pc;
      end else if (accept) begin
        fetch_pc <= fetch_pc + fetch_pkg::ADDR_W'(4);
      end

      if (accept) begin
        in_flight <= 1'b1;
      end else if (fetch_done) begin
        in_flight <= 1'b0;
      end

      fetch_valid <= !jump_valid && !accept && !in_flight && room;
    end
  end

  // pending request holds with its address until taken or redirected
  a_fetch_pc_stable: assert property (
    @(posedge aclk) disable iff (reset)
    fetch_valid && !addr_ok && !jump_valid |=> fetch_valid && $stable(fetch_pc)
  );

endmodule

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // datapath widths
  localparam int ADDR_W  = 32;
  localparam int INSTR_W = 32;

  // first fetch address out of reset
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h1c00_0000;

  // rd_type toward the bridge, single word read
  localparam logic [2:0] RD_TYPE_WORD = 3'b010;

  // decode side pop request
  localparam logic [1:0] POP_NONE = 2'd0;
  localparam logic [1:0] POP_ONE  = 2'd1;
  localparam logic [1:0] POP_TWO  = 2'd2;

endpackage

`default_nettype wire

/* logic/frontend_top.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
  parameter int                           ib_depth = 8,
  parameter logic [fetch_pkg::ADDR_W-1:0] reset_pc = fetch_pkg::RESET_PC
) (
  input  logic                          aclk,
  input  logic                          reset,
  // redirect
  input  logic                          jump_valid,
  input  logic [fetch_pkg::ADDR_W-1:0]  jump_pc,
  // decode side
  input  logic [1:0]                    pop_op,
  output logic                          instr0_valid,
  output logic [fetch_pkg::ADDR_W-1:0]  instr0_pc,
  output logic [fetch_pkg::INSTR_W-1:0] instr0,
  output logic                          instr1_valid,
  output logic [fetch_pkg::ADDR_W-1:0]  instr1_pc,
  output logic [fetch_pkg::INSTR_W-1:0] instr1,
  // AXI read
  output logic [axi_pkg::ID_W-1:0]      arid,
  output logic [31:0]                   araddr,
  output logic [7:0]                    arlen,
  output logic [2:0]                    arsize,
  output logic [1:0]                    arburst,
  output logic [1:0]                    arlock,
  output logic [3:0]                    arcache,
  output logic [2:0]                    arprot,
  output logic                          arvalid,
  input  logic                          arready,
  input  logic [axi_pkg::ID_W-1:0]      rid,
  input  logic [31:0]                   rdata,
  input  logic [1:0]                    rresp,
  input  logic                          rlast,
  input  logic                          rvalid,
  output logic                          rready
);

  logic                          fetch_valid;
  logic [fetch_pkg::ADDR_W-1:0]  fetch_pc;
  logic                          addr_ok;
  logic                          fetch_done;
  logic [$clog2(ib_depth):0]     free_count;
  logic                          rd_req;
  logic [2:0]                    rd_type;
  logic [fetch_pkg::ADDR_W-1:0]  rd_addr;
  logic                          rd_rdy;
  logic                          ret_valid;
  logic                          ret_last;
  logic [fetch_pkg::INSTR_W-1:0] ret_data;
  logic                          data_ok;
  logic [fetch_pkg::ADDR_W-1:0]  data_pc;
  logic [fetch_pkg::INSTR_W-1:0] data_instr;

  fetch_pc_gen #(.ib_depth(ib_depth), .reset_pc(reset_pc)) fetch_pc_gen_i (
    .aclk, .reset, .jump_valid, .jump_pc, .free_count, .fetch_done,
    .fetch_valid, .fetch_pc, .addr_ok
  );

  icache_bypass icache_bypass_i (
    .aclk, .reset, .flush(jump_valid), .fetch_valid, .fetch_pc, .addr_ok,
    .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
    .data_ok, .data_pc, .data_instr, .fetch_done
  );

  instr_buffer #(.ib_depth(ib_depth)) instr_buffer_i (
    .aclk, .reset, .flush(jump_valid), .push(data_ok), .push_pc(data_pc),
    .push_instr(data_instr), .pop_op, .free_count,
    .instr0_valid, .instr0_pc, .instr0, .instr1_valid, .instr1_pc, .instr1
  );

  axi_read_bridge axi_read_bridge_i (
    .aclk, .reset, .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
    .arid, .araddr, .arlen, .arsize, .arburst, .arlock, .arcache, .arprot, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready
  );

endmodule

`default_nettype wire

/* logic/icache_bypass.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_bypass (
  input  logic                          aclk,
  input  logic                          reset,
  input  logic                          flush,
  // fetch request
  input  logic                          fetch_valid,
  input  logic [fetch_pkg::ADDR_W-1:0]  fetch_pc,
  output logic                          addr_ok,
  // bridge read port
  output logic                          rd_req,
  output logic [2:0]                    rd_type,
  output logic [fetch_pkg::ADDR_W-1:0]  rd_addr,
  input  logic                          rd_rdy,
  input  logic                          ret_valid,
  input  logic                          ret_last,
  input  logic [fetch_pkg::INSTR_W-1:0] ret_data,
  // result toward the buffer
  output logic                          data_ok,
  output logic [fetch_pkg::ADDR_W-1:0]  data_pc,
  output logic [fetch_pkg::INSTR_W-1:0] data_instr,
  output logic                          fetch_done
);

  localparam logic [1:0] s_idle = 2'd0;
  localparam logic [1:0] s_req  = 2'd1;
  localparam logic [1:0] s_wait = 2'd2;

  logic [1:0]                   state;
  logic [fetch_pkg::ADDR_W-1:0] pc_q;
  logic                         drop;
  logic                         ret_done;

  // no new fetch in a redirect cycle
  assign addr_ok  = (state == s_idle) && fetch_valid && !flush;
  assign rd_req   = state == s_req;
  assign rd_type  = fetch_pkg::RD_TYPE_WORD;
  assign rd_addr  = pc_q;
  assign ret_done = (state == s_wait) && ret_valid && ret_last;

  always_ff @(posedge aclk) begin
    if (reset) begin
      state      <= s_idle;
      drop       <= 1'b0;
      data_ok    <= 1'b0;
      fetch_done <= 1'b0;
    end else begin
      case (state)
        s_idle: if (addr_ok) begin
          state <= s_req;
          drop  <= 1'b0;
        end
        s_req:  if (rd_rdy) state <= s_wait;
        s_wait: if (ret_done) state <= s_idle;
        default: state <= s_idle;
      endcase

      // stale fetch, swallow the beat when it arrives
      if (flush && state != s_idle) drop <= 1'b1;

      data_ok    <= ret_done && !drop && !flush;
      fetch_done <= ret_done;
    end
  end

  always_ff @(posedge aclk) begin
    if (addr_ok) pc_q <= fetch_pc;
    if (ret_done) begin
      data_pc    <= pc_q;
      data_instr <= ret_data;
    end
  end

  // bridge only returns data for the read this unit issued
  a_ret_in_wait: assert property (
    @(posedge aclk) disable iff (reset)
    ret_valid |-> state == s_wait
  );

endmodule

`default_nettype wire

/* logic/instr_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_buffer #(
  parameter int  ib_depth = 8,
  localparam int ptr_w    = $clog2(ib_depth),
  localparam int cnt_w    = $clog2(ib_depth) + 1
) (
  input  logic                          aclk,
  input  logic                          reset,
  input  logic                          flush,
  // single push from the fetch unit
  input  logic                          push,
  input  logic [fetch_pkg::ADDR_W-1:0]  push_pc,
  input  logic [fetch_pkg::INSTR_W-1:0] push_instr,
  // decode side
  input  logic [1:0]                    pop_op,
  output logic [cnt_w-1:0]              free_count,
  output logic                          instr0_valid,
  output logic [fetch_pkg::ADDR_W-1:0]  instr0_pc,
  output logic [fetch_pkg::INSTR_W-1:0] instr0,
  output logic                          instr1_valid,
  output logic [fetch_pkg::ADDR_W-1:0]  instr1_pc,
  output logic [fetch_pkg::INSTR_W-1:0] instr1
);

  logic [fetch_pkg::ADDR_W-1:0]  pc_mem    [ib_depth];
  logic [fetch_pkg::INSTR_W-1:0] instr_mem [ib_depth];

  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] head_nx1;
  logic [ptr_w-1:0] tail;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] pop_num;
  logic [cnt_w-1:0] push_num;

  always_comb begin
    case (pop_op)
      fetch_pkg::POP_NONE: pop_num = '0;
      fetch_pkg::POP_ONE:  pop_num = cnt_w'(1);
      fetch_pkg::POP_TWO:  pop_num = cnt_w'(2);
      default:             pop_num = '0;
    endcase
  end

  assign push_num   = {{(cnt_w-1){1'b0}}, push};
  assign free_count = cnt_w'(ib_depth) - count;
  assign head_nx1   = head + ptr_w'(1);

  // two oldest entries
  assign instr0_valid = count != '0;
  assign instr0_pc    = pc_mem[head];
  assign instr0       = instr_mem[head];
  assign instr1_valid = count >= cnt_w'(2);
  assign instr1_pc    = pc_mem[head_nx1];
  assign instr1       = instr_mem[head_nx1];

  always_ff @(posedge aclk) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= tail + ptr_w'(1);
      head  <= head + ptr_w'(pop_num);
      count <= count + push_num - pop_num;
    end
  end

  always_ff @(posedge aclk) begin
    if (push && !flush) begin
      pc_mem[tail]    <= push_pc;
      instr_mem[tail] <= push_instr;
    end
  end

  // fetch side must leave room before it pushes
  a_no_push_full: assert property (
    @(posedge aclk) disable iff (reset)
    push |-> count != cnt_w'(ib_depth)
  );

  // decode only takes what is presented
  a_pop_in_range: assert property (
    @(posedge aclk) disable iff (reset)
    pop_num <= count
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module frontend_tb -f frontend.f || exit 1

out=$(./obj_dir/Vfrontend_tb)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'Done: no errors' && exit 0 || exit 1

/* verification/frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

  logic                          aclk;
  logic                          reset;
  logic                          jump_valid;
  logic [fetch_pkg::ADDR_W-1:0]  jump_pc;
  logic [1:0]                    pop_op;
  logic                          instr0_valid;
  logic [fetch_pkg::ADDR_W-1:0]  instr0_pc;
  logic [fetch_pkg::INSTR_W-1:0] instr0;
  logic                          instr1_valid;
  logic [fetch_pkg::ADDR_W-1:0]  instr1_pc;
  logic [fetch_pkg::INSTR_W-1:0] instr1;
  logic [axi_pkg::ID_W-1:0]      arid;
  logic [31:0]                   araddr;
  logic [7:0]                    arlen;
  logic [2:0]                    arsize;
  logic [1:0]                    arburst;
  logic [1:0]                    arlock;
  logic [3:0]                    arcache;
  logic [2:0]                    arprot;
  logic                          arvalid;
  logic                          arready;
  logic [axi_pkg::ID_W-1:0]      rid;
  logic [31:0]                   rdata;
  logic [1:0]                    rresp;
  logic                          rlast;
  logic                          rvalid;
  logic                          rready;

  // trace contents
  logic [7:0]  cmd_c[$];
  logic [31:0] cmd_a[$];
  logic [31:0] cmd_b[$];
  string       cmd_name[$];
  logic [31:0] mem [logic [31:0]];
  int          n_cmd;
  bit          loaded;

  string test_name = "reset_state";
  int    test_errors = 0;
  int    total_errors = 0;
  int    n_tests = 0;
  int    n_failed = 0;
  int    n_checks = 0;
  integer seed = 45285;

  // slave model state
  logic [31:0] exp_ar;
  logic [31:0] stale_ar;
  bit          stale_ok;
  logic [31:0] ar_addr_q;
  bit          r_pend;
  logic [1:0]  ar_delay;
  logic [1:0]  r_delay;

  frontend_top #(.ib_depth(8)) dut_i (
    .aclk, .reset, .jump_valid, .jump_pc, .pop_op,
    .instr0_valid, .instr0_pc, .instr0, .instr1_valid, .instr1_pc, .instr1,
    .arid, .araddr, .arlen, .arsize, .arburst, .arlock, .arcache, .arprot, .arvalid, .arready,
    .rid, .rdata, .rresp, .rlast, .rvalid, .rready
  );

  always #20 aclk = ~aclk;

  task automatic count_error(input string msg);
    $display("test %0s: %0s", test_name, msg);
    test_errors++;
    total_errors++;
  endtask

  task automatic check_pc(input logic [fetch_pkg::ADDR_W-1:0] exp,
                          input logic [fetch_pkg::ADDR_W-1:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("CHECK FAILED %0s pc expected %h actual %h", test_name, exp, act);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic check_instr(input logic [fetch_pkg::INSTR_W-1:0] exp,
                             input logic [fetch_pkg::INSTR_W-1:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("CHECK FAILED %0s instr expected %h actual %h", test_name, exp, act);
      test_errors++;
      total_errors++;
    end
  endtask

  // single word INCR read with the fetch id, normal uncached access
  task automatic compare_ar_fields(input logic [axi_pkg::ID_W-1:0] id,
                                   input logic [7:0]               len,
                                   input logic [2:0]               size,
                                   input logic [1:0]               burst,
                                   input logic [1:0]               lock,
                                   input logic [3:0]               cache,
                                   input logic [2:0]               prot);
    logic [axi_pkg::ID_W+21:0] exp;
    logic [axi_pkg::ID_W+21:0] act;
    exp = {axi_pkg::AR_ID_FETCH, 8'd0, axi_pkg::SIZE_WORD, axi_pkg::BURST_INCR,
           2'b00, 4'b0000, 3'b000};
    act = {id, len, size, burst, lock, cache, prot};
    n_checks++;
    if (exp !== act) begin
      $display("CHECK FAILED %0s ar fields expected %h actual %h", test_name, exp, act);
      test_errors++;
      total_errors++;
    end
  endtask

  task automatic end_test();
    n_tests++;
    if (test_errors != 0) n_failed++;
    $display("test %0s: %0s, %0d errors", test_name, test_errors == 0 ? "ok" : "failed",
             test_errors);
    test_errors = 0;
  endtask

  // unlisted words get the inverted address
  function automatic logic [31:0] read_word(input logic [31:0] a);
    if (mem.exists(a)) return mem[a];
    return ~a;
  endfunction

  task automatic load_trace();
    int          fd;
    string       line;
    string       nm;
    logic [7:0]  c;
    logic [31:0] a;
    logic [31:0] b;
    fd = $fopen("verification/frontend_trace.txt", "r");
    if (fd == 0) begin
      count_error("trace file could not be opened");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      a = '0;
      b = '0;
      nm = "";
      if (line.getc(0) == "T") void'($sscanf(line, "%c %s", c, nm));
      else void'($sscanf(line, "%c %h %h", c, a, b));
      if (c == "M") mem[a] = b;
      cmd_c.push_back(c);
      cmd_a.push_back(a);
      cmd_b.push_back(b);
      cmd_name.push_back(nm);
    end
    $fclose(fd);
    n_cmd = cmd_c.size();
  endtask

  task automatic check_quiet_reset();
    if (arvalid || rready || instr0_valid || instr1_valid)
      count_error("handshake or valid output high around reset");
  endtask

  // AXI slave with random arready and rvalid delays
  always @(posedge aclk) begin
    if (reset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      r_pend   = 0;
      ar_delay = '0;
      stale_ok = 0;
      exp_ar   = fetch_pkg::RESET_PC;
    end else begin
      if (arvalid && arready) begin
        compare_ar_fields(arid, arlen, arsize, arburst, arlock, arcache, arprot);
        if (araddr[1:0] != 2'b00) count_error("araddr is not word aligned");
        if (stale_ok && araddr == stale_ar && araddr != exp_ar) begin
          stale_ok = 0;
        end else begin
          check_pc(exp_ar, araddr);
          exp_ar   = exp_ar + 32'd4;
          stale_ok = 0;
        end
        arready   <= 1'b0;
        ar_addr_q = araddr;
        r_pend    = 1;
        r_delay   = 2'($random(seed));
      end else if (arvalid) begin
        if (ar_delay == 2'd0) arready <= 1'b1;
        else ar_delay = ar_delay - 2'd1;
      end else begin
        ar_delay = 2'($random(seed));
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (r_pend && !rvalid) begin
        if (r_delay == 2'd0) begin
          rvalid <= 1'b1;
          rdata  <= read_word(ar_addr_q);
          r_pend = 0;
        end else begin
          r_delay = r_delay - 2'd1;
        end
      end
      // a fetch already past the icache may still show its old address
      if (jump_valid) begin
        stale_ar = exp_ar;
        stale_ok = 1;
        exp_ar   = jump_pc;
      end
    end
  end

  initial begin
    wait (loaded);
    #(n_cmd * 40 * 40);
    $display("watchdog expired before the trace finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int          k;
    logic [1:0]  code;
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] in0;
    logic [31:0] in1;
    aclk       = 1'b0;
    reset      = 1'b1;
    jump_valid = 1'b0;
    jump_pc    = '0;
    pop_op     = fetch_pkg::POP_NONE;
    arready    = 1'b0;
    rvalid     = 1'b0;
    rdata      = '0;
    rid        = axi_pkg::AR_ID_FETCH;
    rresp      = axi_pkg::RESP_OKAY;
    rlast      = 1'b1;
    load_trace();
    loaded = 1;
    @(posedge aclk);
    @(negedge aclk);
    check_quiet_reset();
    @(posedge aclk);
    reset <= 1'b0;
    @(negedge aclk);
    check_quiet_reset();
    for (int i = 0; i < n_cmd; i++) begin
      case (cmd_c[i])
        "T": begin
          end_test();
          test_name = cmd_name[i];
        end
        "J": begin
          @(posedge aclk);
          jump_valid <= 1'b1;
          jump_pc    <= cmd_a[i];
          @(posedge aclk);
          jump_valid <= 1'b0;
        end
        "W": repeat (cmd_a[i]) @(posedge aclk);
        "Q": begin
          repeat (cmd_a[i]) begin
            @(negedge aclk);
            if (arvalid) count_error("arvalid high while the buffer is full");
          end
        end
        "P": begin
          code = 2'(cmd_a[i]);
          k = (code == fetch_pkg::POP_TWO) ? 2 : 1;
          do @(negedge aclk);
          while (!(instr0_valid && (k == 1 || instr1_valid)));
          pc0 = instr0_pc;
          in0 = instr0;
          pc1 = instr1_pc;
          in1 = instr1;
          @(posedge aclk);
          pop_op <= code;
          @(posedge aclk);
          pop_op <= fetch_pkg::POP_NONE;
          if (i + k >= n_cmd || cmd_c[i+1] != "E" || (k == 2 && cmd_c[i+2] != "E")) begin
            count_error("pop in trace lacks its expected entries");
          end else begin
            check_pc(cmd_a[i+1], pc0);
            check_instr(cmd_b[i+1], in0);
            if (k == 2) begin
              check_pc(cmd_a[i+2], pc1);
              check_instr(cmd_b[i+2], in1);
            end
            i = i + k;
          end
        end
        default: ;
      endcase
    end
    end_test();
    $display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed, n_checks,
             total_errors);
    if (total_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/frontend_trace.txt */
# M addr word = memory image, T name = test start, J addr = jump, P n = pop n entries
# E pc instr = expected popped entry, W n = idle cycles, Q n = cycles with arvalid low
M 1c000000 00100093
M 1c000004 00200113
M 1c000008 002081b3
M 1c00000c 40208233
T sequential
P 1
E 1c000000 00100093
P 2
E 1c000004 00200113
E 1c000008 002081b3
P 1
E 1c00000c 40208233
P 2
E 1c000010 e3ffffef
E 1c000014 e3ffffeb
T jump
J 1c000100
P 1
E 1c000100 e3fffeff
P 2
E 1c000104 e3fffefb
E 1c000108 e3fffef7
T jump_in_flight
J 1c000300
W 3
J 1c000400
P 1
E 1c000400 e3fffbff
P 2
E 1c000404 e3fffbfb
E 1c000408 e3fffbf7
T buffer_full
J 1c000200
W 120
Q 20
P 2
E 1c000200 e3fffdff
E 1c000204 e3fffdfb
P 2
E 1c000208 e3fffdf7
E 1c00020c e3fffdf3
P 2
E 1c000210 e3fffdef
E 1c000214 e3fffdeb
P 1
E 1c000218 e3fffde7
P 2
E 1c00021c e3fffde3
E 1c000220 e3fffddf
